// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_ntsc_capture
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
src/ntsc_pkg.sv
src/ccir656_sync.sv
src/ycrcb_demux.sv
src/pixel_pair_packer.sv
src/ntsc_capture.sv
test/ntsc_scoreboard.sv
test/ntsc_capture_chk.sv
test/tb_ntsc_capture.sv

// File: src/ccir656_sync.sv
`timescale 1ns/1ps

module ccir656_sync (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [ntsc_pkg::WORD_W-1:0] video_word,
  output logic                        line_start,
  output logic                        line_active,
  output logic                        line_abort,
  output logic                        field
);

  ntsc_pkg::sync_state_t state;

  // Word matches one of the eight legal codes
  logic code_legal;

  // Legal code that opens an active video line (H=0, V=0)
  logic active_sav;

  // Start of a new preamble
  logic is_ff;

  // Second or third preamble word
  logic is_00;

  ////////////////////////////////////////
  // Code decode
  ////////////////////////////////////////

  always_comb
  begin
    code_legal = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      if (video_word == ntsc_pkg::TIMING_CODES[i])
        code_legal = 1'b1;
    end
  end

  assign is_ff      = (video_word == ntsc_pkg::PREAMBLE_FF);
  assign is_00      = (video_word == ntsc_pkg::PREAMBLE_00);
  assign active_sav = code_legal && !video_word[7] && !video_word[6];

  // High for every data word of an active line
  assign line_active = (state == ntsc_pkg::ACTIVE);

  ////////////////////////////////////////
  // Preamble hunt FSM
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state      <= ntsc_pkg::HUNT;
      line_start <= 1'b0;
      line_abort <= 1'b0;
      field      <= 1'b0;
    end
    else
    begin
      // Strobes last one cycle
      line_start <= 1'b0;
      line_abort <= 1'b0;
      case (state)
        ntsc_pkg::HUNT:
          if (is_ff)
            state <= ntsc_pkg::GOT_FF;
        ntsc_pkg::GOT_FF:
          // Repeated FF keeps us one step in
          if (is_00)
            state <= ntsc_pkg::GOT_00A;
          else if (!is_ff)
            state <= ntsc_pkg::HUNT;
        ntsc_pkg::GOT_00A:
          if (is_00)
            state <= ntsc_pkg::GOT_00B;
          else if (is_ff)
            state <= ntsc_pkg::GOT_FF;
          else
            state <= ntsc_pkg::HUNT;
        ntsc_pkg::GOT_00B:
        begin
          // EAV, blanking SAV and illegal words all fall back to the hunt
          if (code_legal)
            field <= video_word[8];
          if (active_sav)
          begin
            state      <= ntsc_pkg::ACTIVE;
            line_start <= 1'b1;
          end
          else
            state <= ntsc_pkg::HUNT;
        end
        ntsc_pkg::ACTIVE:
          // Any FF ends the line, whether early or a regular EAV
          if (is_ff)
          begin
            state      <= ntsc_pkg::GOT_FF;
            line_abort <= 1'b1;
          end
        default:
          state <= ntsc_pkg::HUNT;
      endcase
    end
  end

endmodule

// File: src/ntsc_capture.sv
`timescale 1ns/1ps

module ntsc_capture (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [ntsc_pkg::WORD_W-1:0] video_word,
  output logic [ntsc_pkg::PAIR_W-1:0] captured_pixels,
  output logic                        pixel_flag,
  output logic                        frame_flag,
  output logic                        field
);

  // Line control from the sync stage
  logic line_start;
  logic line_active;
  logic line_abort;

  // Pixels out of the demux
  logic [ntsc_pkg::PIX_W-1:0] pixel;
  logic                       pixel_valid;

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////

  ccir656_sync u_sync (
    .clk         (clk),
    .reset       (reset),
    .video_word  (video_word),
    .line_start  (line_start),
    .line_active (line_active),
    .line_abort  (line_abort),
    .field       (field)
  );

  // Sample separation
  ycrcb_demux u_demux (
    .clk         (clk),
    .reset       (reset),
    .video_word  (video_word),
    .line_start  (line_start),
    .line_active (line_active),
    .pixel       (pixel),
    .pixel_valid (pixel_valid)
  );

  ////////////////////////////////////////
  // Output side
  ////////////////////////////////////////

  pixel_pair_packer u_packer (
    .clk             (clk),
    .reset           (reset),
    .pixel           (pixel),
    .pixel_valid     (pixel_valid),
    .line_start      (line_start),
    .line_abort      (line_abort),
    .field           (field),
    .captured_pixels (captured_pixels),
    .pixel_flag      (pixel_flag),
    .frame_flag      (frame_flag)
  );

endmodule

// File: src/ntsc_pkg.sv
package ntsc_pkg;

  ////////////////////////////////////////
  // Stream and pixel widths
  ////////////////////////////////////////

  // One CCIR656 word per clock from the decoder
  localparam int WORD_W = 10;

  // Bits kept per component after truncation
  localparam int PACK_W = 6;

  // Two packed pixels, three components each
  localparam int PAIR_W = 6 * PACK_W;

  // Assembled pixel is {Y, Cr, Cb} at full word width
  localparam int PIX_W = 3 * WORD_W;

  ////////////////////////////////////////
  // Timing reference words
  ////////////////////////////////////////

  // Preamble is FF, 00, 00 then the timing code
  localparam logic [WORD_W-1:0] PREAMBLE_FF = 10'h3FF;
  localparam logic [WORD_W-1:0] PREAMBLE_00 = 10'h000;

  // Legal timing codes
  // Bit 8 is F, bit 7 is V, bit 6 is H, low bits are protection
  localparam logic [7:0][WORD_W-1:0] TIMING_CODES = {
    10'h3C4, 10'h3B0, 10'h368, 10'h31C,
    10'h2D8, 10'h2AC, 10'h274, 10'h200
  };

  // Chroma midpoint, used until the first Cr of a line arrives
  localparam logic [WORD_W-1:0] NEUTRAL_CHROMA = 10'h200;

  ////////////////////////////////////////
  // State encodings
  ////////////////////////////////////////

  // Preamble hunt
  typedef enum logic [2:0] {
    HUNT,
    GOT_FF,
    GOT_00A,
    GOT_00B,
    ACTIVE
  } sync_state_t;

  // Position inside a Cb Y Cr Y group
  typedef enum logic [1:0] {
    PH_CB,
    PH_Y0,
    PH_CR,
    PH_Y1
  } sample_phase_t;

endpackage

// File: src/pixel_pair_packer.sv
`timescale 1ns/1ps

module pixel_pair_packer (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [ntsc_pkg::PIX_W-1:0]  pixel,
  input  logic                        pixel_valid,
  input  logic                        line_start,
  input  logic                        line_abort,
  input  logic                        field,
  output logic [ntsc_pkg::PAIR_W-1:0] captured_pixels,
  output logic                        pixel_flag,
  output logic                        frame_flag
);

  localparam int HALF_W = ntsc_pkg::PAIR_W / 2;

  // Upper bits of Y, Cr and Cb in that order
  function automatic logic [HALF_W-1:0] trunc_pixel(input logic [ntsc_pkg::PIX_W-1:0] p);
    logic [ntsc_pkg::PACK_W-1:0] y_t;
    logic [ntsc_pkg::PACK_W-1:0] cr_t;
    logic [ntsc_pkg::PACK_W-1:0] cb_t;
    y_t  = p[3*ntsc_pkg::WORD_W-1 -: ntsc_pkg::PACK_W];
    cr_t = p[2*ntsc_pkg::WORD_W-1 -: ntsc_pkg::PACK_W];
    cb_t = p[ntsc_pkg::WORD_W-1 -: ntsc_pkg::PACK_W];
    return {y_t, cr_t, cb_t};
  endfunction

  // First pixel of an open pair
  logic [HALF_W-1:0] first_half;
  logic              half_valid;

  // Field of the previous line start
  logic prev_field;

  ////////////////////////////////////////
  // Pair assembly
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      half_valid <= 1'b0;
      pixel_flag <= 1'b0;
    end
    else
    begin
      pixel_flag <= 1'b0;
      // A line boundary drops any open half pair
      // and also the pixel the aborting FF word produced
      if (line_start || line_abort)
        half_valid <= 1'b0;
      else if (pixel_valid)
      begin
        half_valid <= !half_valid;
        pixel_flag <= half_valid;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (pixel_valid && !half_valid)
      first_half <= trunc_pixel(pixel);
    if (pixel_valid && half_valid)
      captured_pixels <= {first_half, trunc_pixel(pixel)};
  end

  ////////////////////////////////////////
  // Frame strobe
  ////////////////////////////////////////

  // Odd field (F=0) following an even one marks a new frame
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      prev_field <= 1'b1;
      frame_flag <= 1'b0;
    end
    else
    begin
      frame_flag <= line_start && prev_field && !field;
      if (line_start)
        prev_field <= field;
    end
  end

endmodule

// File: src/ycrcb_demux.sv
`timescale 1ns/1ps

module ycrcb_demux (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [ntsc_pkg::WORD_W-1:0] video_word,
  input  logic                        line_start,
  input  logic                        line_active,
  output logic [ntsc_pkg::PIX_W-1:0]  pixel,
  output logic                        pixel_valid
);

  ntsc_pkg::sample_phase_t phase;

  // Phase of the word sampled this cycle
  // First word after line start is always Cb
  ntsc_pkg::sample_phase_t cur_phase;
  ntsc_pkg::sample_phase_t next_phase;

  // Chroma holding registers
  logic [ntsc_pkg::WORD_W-1:0] cb_hold;
  logic [ntsc_pkg::WORD_W-1:0] cr_hold;

  logic is_y;

  assign cur_phase = line_start ? ntsc_pkg::PH_CB : phase;
  assign is_y = (cur_phase == ntsc_pkg::PH_Y0) || (cur_phase == ntsc_pkg::PH_Y1);

  always_comb
  begin
    case (cur_phase)
      ntsc_pkg::PH_CB: next_phase = ntsc_pkg::PH_Y0;
      ntsc_pkg::PH_Y0: next_phase = ntsc_pkg::PH_CR;
      ntsc_pkg::PH_CR: next_phase = ntsc_pkg::PH_Y1;
      default:         next_phase = ntsc_pkg::PH_CB;
    endcase
  end

  ////////////////////////////////////////
  // Phase tracking and valid strobe
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      phase       <= ntsc_pkg::PH_CB;
      pixel_valid <= 1'b0;
    end
    else
    begin
      pixel_valid <= line_active && is_y;
      if (line_active)
        phase <= next_phase;
    end
  end

  ////////////////////////////////////////
  // Sample capture and pixel assembly
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    // No Cr seen yet in this line
    if (line_start)
      cr_hold <= ntsc_pkg::NEUTRAL_CHROMA;
    else if (line_active && cur_phase == ntsc_pkg::PH_CR)
      cr_hold <= video_word;
    if (line_active && cur_phase == ntsc_pkg::PH_CB)
      cb_hold <= video_word;
    // Y0 pairs with the previous Cr, Y1 with this group's Cr
    if (line_active && is_y)
      pixel <= {video_word, cr_hold, cb_hold};
  end

endmodule

// File: test/ntsc_capture_chk.sv
`timescale 1ns/1ps

module ntsc_capture_chk (
  input logic                  clk,
  input logic                  reset,
  input logic                  pixel_flag,
  input logic                  frame_flag,
  input logic                  line_start,
  input logic                  line_abort,
  input ntsc_pkg::sync_state_t sync_state
);

  int assert_failures;

  // A pair takes four words, so flags are at least four cycles apart
  a_flag_gap: assert property (@(posedge clk) disable iff (reset)
    pixel_flag |-> !$past(pixel_flag) && !$past(pixel_flag, 2) && !$past(pixel_flag, 3))
  else
  begin
    $error("pixel_flag strobes closer than four cycles");
    assert_failures++;
  end

  // Strobes stay quiet while in reset and for the cycle after
  a_reset_quiet: assert property (@(posedge clk)
    (reset || $fell(reset)) |=> !(pixel_flag || frame_flag || line_start || line_abort))
  else
  begin
    $error("Strobe high during or right after reset");
    assert_failures++;
  end

  // Frame start only follows an active SAV
  a_frame_active: assert property (@(posedge clk) disable iff (reset)
    frame_flag |-> $past(sync_state) == ntsc_pkg::ACTIVE)
  else
  begin
    $error("frame_flag without an active line");
    assert_failures++;
  end

endmodule

bind ntsc_capture ntsc_capture_chk u_chk (
  .clk        (clk),
  .reset      (reset),
  .pixel_flag (pixel_flag),
  .frame_flag (frame_flag),
  .line_start (line_start),
  .line_abort (line_abort),
  .sync_state (u_sync.state)
);

// File: test/ntsc_cases.txt
# name code_index pair_count abort_pixel filler_words
# code_index 0..7 picks 200 274 2AC 2D8 31C 368 3B0 3C4, 8 is an illegal word
odd_first 0 6 0 7
odd_second 0 4 0 3
blank_odd 2 3 0 5
eav_odd 1 2 0 4
illegal_code 8 3 0 9
even_line 4 5 0 4
blank_even 6 2 0 6
eav_even 5 1 0 2
odd_after_even 0 3 0 6
abort_odd_px 0 6 5 3
after_abort 0 4 0 0
abort_first_px 0 3 1 5
after_abort_b 0 2 0 2
abort_even_px 4 4 4 3
odd_new_frame 0 3 0 1
empty_line 0 0 0 4
eav_even_b 7 2 0 3
filler_run 8 0 0 20
final_line 0 8 0 4

// File: test/ntsc_scoreboard.sv
`timescale 1ns/1ps

module ntsc_scoreboard (
  input  logic                        clk,
  input  logic                        reset,
  input  int                          cycle,
  input  logic [ntsc_pkg::PAIR_W-1:0] captured_pixels,
  input  logic                        pixel_flag,
  input  logic                        frame_flag,
  input  logic                        field,
  output int                          pair_errors,
  output int                          frame_errors,
  output int                          field_errors
);

  // Expected pairs in arrival order
  string                       pair_name [$];
  logic [ntsc_pkg::PAIR_W-1:0] pair_value [$];
  int                          pair_due [$];

  // Expected frame strobes
  string frame_name [$];
  int    frame_due [$];

  // Expected field level after each timing code
  string field_name [$];
  logic  field_value [$];
  int    field_due [$];

  task automatic expect_pair(input string name, input logic [ntsc_pkg::PAIR_W-1:0] value,
                             input int due);
    pair_name.push_back(name);
    pair_value.push_back(value);
    pair_due.push_back(due);
  endtask

  task automatic expect_frame(input string name, input int due);
    frame_name.push_back(name);
    frame_due.push_back(due);
  endtask

  task automatic expect_field(input string name, input logic value, input int due);
    field_name.push_back(name);
    field_value.push_back(value);
    field_due.push_back(due);
  endtask

  function automatic int outstanding();
    return pair_due.size() + frame_due.size() + field_due.size();
  endfunction

  function automatic void drop_pair();
    void'(pair_name.pop_front());
    void'(pair_value.pop_front());
    void'(pair_due.pop_front());
  endfunction

  function automatic void drop_frame();
    void'(frame_name.pop_front());
    void'(frame_due.pop_front());
  endfunction

  function automatic void drop_field();
    void'(field_name.pop_front());
    void'(field_value.pop_front());
    void'(field_due.pop_front());
  endfunction

  // Outputs settle after the rising edge, compare on the falling one
  always @(negedge clk)
  begin
    if (reset)
    begin
      pair_errors = 0;
      frame_errors = 0;
      field_errors = 0;
    end
    else
    begin
      if (pixel_flag && pair_due.size() == 0)
      begin
        $display("Unexpected pixel_flag at cycle %0d with no pair pending", cycle);
        pair_errors++;
      end
      else if (pixel_flag)
      begin
        if (captured_pixels !== pair_value[0])
        begin
          $display("ERR %s: pair expected %h actual %h", pair_name[0], pair_value[0],
                   captured_pixels);
          pair_errors++;
        end
        if (cycle != pair_due[0])
        begin
          $display("ERR %s: pixel_flag cycle expected %0d actual %0d", pair_name[0],
                   pair_due[0], cycle);
          pair_errors++;
        end
        drop_pair();
      end
      else if (pair_due.size() > 0 && cycle > pair_due[0])
      begin
        $display("Missing pixel_flag in %s, it was due at cycle %0d", pair_name[0],
                 pair_due[0]);
        pair_errors++;
        drop_pair();
      end
      // Frame strobes
      if (frame_flag && frame_due.size() == 0)
      begin
        $display("Unexpected frame_flag at cycle %0d", cycle);
        frame_errors++;
      end
      else if (frame_flag)
      begin
        if (cycle != frame_due[0])
        begin
          $display("ERR %s: frame_flag cycle expected %0d actual %0d", frame_name[0],
                   frame_due[0], cycle);
          frame_errors++;
        end
        drop_frame();
      end
      else if (frame_due.size() > 0 && cycle > frame_due[0])
      begin
        $display("Missing frame_flag in %s, it was due at cycle %0d", frame_name[0],
                 frame_due[0]);
        frame_errors++;
        drop_frame();
      end
      // Field level once the code word has been taken
      if (field_due.size() > 0 && cycle >= field_due[0])
      begin
        if (field !== field_value[0])
        begin
          $display("ERR %s: field expected %b actual %b", field_name[0],
                   field_value[0], field);
          field_errors++;
        end
        drop_field();
      end
    end
  end

endmodule

// File: test/tb_ntsc_capture.sv
`timescale 1ns/1ps

module tb_ntsc_capture;

  localparam int MAX_CASES = 32;

  logic                        clk;
  logic                        reset;
  logic [ntsc_pkg::WORD_W-1:0] video_word;
  logic [ntsc_pkg::PAIR_W-1:0] captured_pixels;
  logic                        pixel_flag;
  logic                        frame_flag;
  logic                        field;

  // Rising edges since time zero
  int cyc = 0;
  int cycle_limit = 0;
  int pair_errors;
  int frame_errors;
  int field_errors;
  int setup_errors = 0;
  logic [31:0] rng = 32'h45dd_ea5a;

  // Scenario table from the cases file
  string case_name [MAX_CASES];
  int    case_code [MAX_CASES];
  int    case_pairs [MAX_CASES];
  int    case_abort [MAX_CASES];
  int    case_filler [MAX_CASES];
  int    num_cases = 0;

  // Field of the last active line start, reset counts as field 1
  logic last_field = 1'b1;

  // F bit of the last legal code, unknown until the first one
  logic exp_field = 1'bx;

  ntsc_capture u_ntsc_capture (
    .clk             (clk),
    .reset           (reset),
    .video_word      (video_word),
    .captured_pixels (captured_pixels),
    .pixel_flag      (pixel_flag),
    .frame_flag      (frame_flag),
    .field           (field)
  );

  ntsc_scoreboard u_scoreboard (
    .clk             (clk),
    .reset           (reset),
    .cycle           (cyc),
    .captured_pixels (captured_pixels),
    .pixel_flag      (pixel_flag),
    .frame_flag      (frame_flag),
    .field           (field),
    .pair_errors     (pair_errors),
    .frame_errors    (frame_errors),
    .field_errors    (field_errors)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Data range 004..3FB, never a preamble word
  function automatic logic [9:0] random_data();
    rng = xorshift32(rng);
    return 10'h004 + 10'(rng % 32'd1016);
  endfunction

  // Index bits are {F, V, H}, index 8 is an illegal word
  function automatic logic [9:0] code_word(input int idx);
    case (idx)
      0:       return 10'h200;
      1:       return 10'h274;
      2:       return 10'h2AC;
      3:       return 10'h2D8;
      4:       return 10'h31C;
      5:       return 10'h368;
      6:       return 10'h3B0;
      7:       return 10'h3C4;
      default: return 10'h155;
    endcase
  endfunction

  // Lone FF and 00 words mixed into random idle data
  function automatic logic [9:0] filler_word(input int j);
    if (j % 5 == 2)
      return 10'h3FF;
    else if (j % 5 == 4)
      return 10'h000;
    else
      return random_data();
  endfunction

  function automatic logic [ntsc_pkg::PACK_W-1:0] top_bits(input logic [9:0] v);
    return v[ntsc_pkg::WORD_W-1 -: ntsc_pkg::PACK_W];
  endfunction

  task automatic drive_word(input logic [ntsc_pkg::WORD_W-1:0] w);
    @(negedge clk);
    video_word = w;
  endtask

  // Timing code word, field follows only the legal ones
  task automatic drive_code(input string name, input logic [ntsc_pkg::WORD_W-1:0] w,
                            input logic legal);
    drive_word(w);
    if (legal)
      exp_field = w[8];
    if (!$isunknown(exp_field))
      u_scoreboard.expect_field(name, exp_field, cyc + 1);
  endtask

  task automatic read_cases();
    int    fd;
    int    code;
    int    pairs;
    int    abort_px;
    int    filler;
    string line;
    string name;
    fd = $fopen("test/ntsc_cases.txt", "r");
    if (fd == 0)
      $display("Cannot open the scenario file test/ntsc_cases.txt");
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        // Skip comments and blank lines
        if (line.len() > 1 && line[0] != "#" && num_cases < MAX_CASES)
        begin
          if ($sscanf(line, "%s %d %d %d %d", name, code, pairs, abort_px, filler) == 5)
          begin
            case_name[num_cases]   = name;
            case_code[num_cases]   = code;
            case_pairs[num_cases]  = pairs;
            case_abort[num_cases]  = abort_px;
            case_filler[num_cases] = filler;
            num_cases++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////
  // One scenario line
  ////////////////////////////////////////

  task automatic run_case(input int idx);
    logic [ntsc_pkg::WORD_W-1:0] words [$];
    logic [ntsc_pkg::WORD_W-1:0] code;
    logic [ntsc_pkg::WORD_W-1:0] cr_prev;
    logic [ntsc_pkg::PAIR_W-1:0] pair;
    logic                        active;
    int                          stop;
    code = code_word(case_code[idx]);
    // Legal SAV with V=0 opens an active line
    active = (case_code[idx] < 8) && !code[7] && !code[6];
    for (int j = 0; j < case_filler[idx]; j++)
      drive_word(filler_word(j));
    drive_word(10'h3FF);
    drive_word(10'h000);
    drive_word(10'h000);
    drive_code(case_name[idx], code, case_code[idx] < 8);
    if (active)
    begin
      // New frame when the odd field follows the even one
      if (last_field && !code[8])
        u_scoreboard.expect_frame(case_name[idx], cyc + 2);
      last_field = code[8];
    end
    for (int w = 0; w < 4 * case_pairs[idx]; w++)
      words.push_back(random_data());
    // Abort replaces the Y word of that pixel with FF
    stop = (case_abort[idx] > 0) ? 2 * case_abort[idx] - 1 : words.size();
    cr_prev = ntsc_pkg::NEUTRAL_CHROMA;
    for (int w = 0; w < stop; w++)
    begin
      drive_word(words[w]);
      if (active && w % 4 == 3)
      begin
        // Y0 carries the previous Cr, Y1 this group's Cr
        pair = {top_bits(words[w-2]), top_bits(cr_prev), top_bits(words[w-3]),
                top_bits(words[w]), top_bits(words[w-1]), top_bits(words[w-3])};
        u_scoreboard.expect_pair(case_name[idx], pair, cyc + 2);
        cr_prev = words[w-1];
      end
    end
    drive_word(10'h3FF);
    // Full lines close with an EAV of the same field
    if (case_abort[idx] == 0)
    begin
      drive_word(10'h000);
      drive_word(10'h000);
      drive_code(case_name[idx],
                 case_code[idx] < 8 ? code_word(case_code[idx] | 1) : code_word(1), 1'b1);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    int total_words;
    int errors;
    reset = 1'b1;
    video_word = '0;
    read_cases();
    if (num_cases == 0)
    begin
      $display("No scenarios found in the cases file");
      setup_errors++;
    end
    total_words = 1;
    for (int i = 0; i < num_cases; i++)
      total_words += case_filler[i] + 4 +
                     ((case_abort[i] > 0) ? 2 * case_abort[i] : 4 * case_pairs[i] + 4);
    cycle_limit = total_words + 200;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < num_cases; i++)
      run_case(i);
    drive_word(10'h040);
    // Let outstanding strobes come due, then watch for stray ones
    while (u_scoreboard.outstanding() > 0)
      @(negedge clk);
    repeat (8) @(negedge clk);
    errors = pair_errors + frame_errors + field_errors + setup_errors +
             u_ntsc_capture.u_chk.assert_failures;
    $display("Errors: %0d pair, %0d frame, %0d field, %0d assertion, %0d setup",
             pair_errors, frame_errors, field_errors,
             u_ntsc_capture.u_chk.assert_failures, setup_errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // Watchdog
  initial
  begin
    wait (cycle_limit > 0);
    wait (cyc >= cycle_limit);
    $display("Timeout: run went past %0d cycles without finishing", cycle_limit);
    $display("Test failures found");
    $finish;
  end

endmodule
